// ==== logic/snd_pkg.sv ====
package snd_pkg;

    // game sample as delivered by the core
    // two's complement or offset binary, depending on the control bit
    typedef logic [15:0] snd_sample_t;

    // modulator code: zero msb, adjusted sample, three zero lsbs
    typedef logic [19:0] snd_code_t;

    // enable divider, one pulse every div + 1 cycles
    typedef logic [7:0] snd_div_t;

    // apb byte address and data word
    typedef logic [3:0]  apb_addr_t;
    typedef logic [31:0] apb_data_t;

    // register map
    localparam apb_addr_t SND_CTRL_ADDR = 4'h0;
    localparam apb_addr_t SND_DIV_ADDR  = 4'h4;

    // control register bit positions
    localparam int CTRL_ENABLE_BIT = 0;
    localparam int CTRL_SIGNED_BIT = 1;
    localparam int CTRL_STEREO_BIT = 2;
    localparam int CTRL_MUTE_BIT   = 3;

    // reset values
    // divider of 3 gives one enable every 4 clk_dac cycles
    localparam snd_div_t SND_DIV_RESET = 8'd3;

    // offset-binary midpoint, used while muted
    localparam snd_sample_t SND_MUTE_SAMPLE = 16'h8000;

endpackage

// ==== logic/snd_cfg_regs.sv ====
module snd_cfg_regs import snd_pkg::*; (
    input  logic      clk_dac,
    input  logic      rst,
    // apb slave
    input  logic      psel_i,
    input  logic      penable_i,
    input  logic      pwrite_i,
    input  apb_addr_t paddr_i,
    input  apb_data_t pwdata_i,
    output apb_data_t prdata_o,
    output logic      pready_o,
    output logic      pslverr_o,
    // control to the audio path
    output logic      ctrl_enable_o,
    output logic      ctrl_signed_o,
    output logic      ctrl_stereo_o,
    output logic      ctrl_mute_o,
    output snd_div_t  cen_div_o
);

    logic     access;
    logic     hit_ctrl;
    logic     hit_div;
    logic     addr_ok;
    logic     wr_ctrl;
    logic     wr_div;

    logic     enable_q;
    logic     signed_q;
    logic     stereo_q;
    logic     mute_q;
    snd_div_t div_q;

    // access phase, no wait states
    assign access   = psel_i & penable_i;
    assign hit_ctrl = (paddr_i == SND_CTRL_ADDR);
    assign hit_div  = (paddr_i == SND_DIV_ADDR);
    assign addr_ok  = hit_ctrl | hit_div;

    assign wr_ctrl  = access & pwrite_i & hit_ctrl;
    assign wr_div   = access & pwrite_i & hit_div;

    assign pready_o  = access;
    assign pslverr_o = access & ~addr_ok;

    // control register
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            enable_q <= 1'b0;
            signed_q <= 1'b0;
            stereo_q <= 1'b0;
            mute_q   <= 1'b0;
        end else if (wr_ctrl) begin
            enable_q <= pwdata_i[CTRL_ENABLE_BIT];
            signed_q <= pwdata_i[CTRL_SIGNED_BIT];
            stereo_q <= pwdata_i[CTRL_STEREO_BIT];
            mute_q   <= pwdata_i[CTRL_MUTE_BIT];
        end
    end

    // divider register
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            div_q <= SND_DIV_RESET;
        end else if (wr_div) begin
            div_q <= pwdata_i[$bits(snd_div_t)-1:0];
        end
    end

    // read mux, unused bits and bad addresses give zero
    always_comb begin
        prdata_o = '0;
        if (hit_ctrl) begin
            prdata_o[CTRL_ENABLE_BIT] = enable_q;
            prdata_o[CTRL_SIGNED_BIT] = signed_q;
            prdata_o[CTRL_STEREO_BIT] = stereo_q;
            prdata_o[CTRL_MUTE_BIT]   = mute_q;
        end else if (hit_div) begin
            prdata_o[$bits(snd_div_t)-1:0] = div_q;
        end
    end

    assign ctrl_enable_o = enable_q;
    assign ctrl_signed_o = signed_q;
    assign ctrl_stereo_o = stereo_q;
    assign ctrl_mute_o   = mute_q;
    assign cen_div_o     = div_q;

endmodule

// ==== logic/snd_cen_gen.sv ====
module snd_cen_gen import snd_pkg::*; (
    input  logic     clk_dac,
    input  logic     rst,
    input  logic     enable_i,
    input  snd_div_t div_i,
    output logic     cen_o
);

    snd_div_t cnt;

    // down-counter, reload from div_i on zero
    // period is div_i + 1 cycles, div_i of 0 means every cycle
    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            cnt   <= '0;
            cen_o <= 1'b0;
        end else if (!enable_i) begin
            // stopped, restart from zero when enabled again
            cnt   <= '0;
            cen_o <= 1'b0;
        end else if (cnt == '0) begin
            // new divider is picked up here
            cnt   <= div_i;
            cen_o <= 1'b1;
        end else begin
            cnt   <= cnt - 1'b1;
            cen_o <= 1'b0;
        end
    end

endmodule

// ==== logic/snd_pcm_format.sv ====
module snd_pcm_format import snd_pkg::*; (
    input  logic        clk_dac,
    input  logic        rst,
    input  logic        cen_i,
    input  logic        signed_i,
    input  logic        stereo_i,
    input  logic        mute_i,
    input  snd_sample_t snd_left_i,
    input  snd_sample_t snd_right_i,
    output snd_code_t   code_left_o,
    output snd_code_t   code_right_o
);

    snd_sample_t src_left;
    snd_sample_t src_right;
    snd_sample_t held_left;
    snd_sample_t held_right;

    // two's complement to offset binary by flipping the sign bit
    function automatic snd_sample_t sign_adj(input snd_sample_t s, input logic sgn);
        return {s[15] ^ sgn, s[14:0]};
    endfunction

    // headroom bit on top, three zero bits below
    function automatic snd_code_t pad_code(input snd_sample_t s);
        return {1'b0, s, 3'b000};
    endfunction

    // mono copies left into right, mute overrides both
    assign src_left  = mute_i ? SND_MUTE_SAMPLE : snd_left_i;
    assign src_right = mute_i ? SND_MUTE_SAMPLE : (stereo_i ? snd_right_i : snd_left_i);

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            held_left  <= '0;
            held_right <= '0;
        end else if (cen_i) begin
            held_left  <= sign_adj(src_left, signed_i);
            held_right <= sign_adj(src_right, signed_i);
        end
    end

    assign code_left_o  = pad_code(held_left);
    assign code_right_o = pad_code(held_right);

endmodule

// ==== logic/snd_sd_dac.sv ====
module snd_sd_dac import snd_pkg::*; (
    input  logic      clk_dac,
    input  logic      rst,
    input  logic      enable_i,
    input  logic      cen_i,
    input  snd_code_t code_i,
    output logic      dac_o
);

    // first-order sigma-delta
    // the carry out of the accumulator is the 1-bit output,
    // so the density of ones is code_i / 2^20
    snd_code_t                  acc;
    logic [$bits(snd_code_t):0] sum;
    logic                       carry;
    snd_code_t                  acc_next;

    // one extra bit for the carry
    assign sum      = {1'b0, acc} + {1'b0, code_i};
    assign carry    = sum[$bits(snd_code_t)];
    assign acc_next = sum[$bits(snd_code_t)-1:0];

    always_ff @(posedge clk_dac or posedge rst) begin
        if (rst) begin
            acc   <= '0;
            dac_o <= 1'b0;
        end else if (!enable_i) begin
            // disabled, output silent and error cleared
            acc   <= '0;
            dac_o <= 1'b0;
        end else if (cen_i) begin
            acc   <= acc_next;
            dac_o <= carry;
        end
    end

endmodule

// ==== logic/snd_out_top.sv ====
module snd_out_top import snd_pkg::*; (
    input  logic        clk_dac,
    input  logic        rst,
    // apb control port
    input  logic        psel_i,
    input  logic        penable_i,
    input  logic        pwrite_i,
    input  apb_addr_t   paddr_i,
    input  apb_data_t   pwdata_i,
    output apb_data_t   prdata_o,
    output logic        pready_o,
    output logic        pslverr_o,
    // game sound
    input  snd_sample_t snd_left_i,
    input  snd_sample_t snd_right_i,
    output logic        snd_pwm_left_o,
    output logic        snd_pwm_right_o
);

    logic      ctrl_enable;
    logic      ctrl_signed;
    logic      ctrl_stereo;
    logic      ctrl_mute;
    snd_div_t  cen_div;
    logic      cen_dac;
    snd_code_t code_left;
    snd_code_t code_right;

    snd_cfg_regs u_regs (
        .clk_dac       ( clk_dac     ),
        .rst           ( rst         ),
        .psel_i        ( psel_i      ),
        .penable_i     ( penable_i   ),
        .pwrite_i      ( pwrite_i    ),
        .paddr_i       ( paddr_i     ),
        .pwdata_i      ( pwdata_i    ),
        .prdata_o      ( prdata_o    ),
        .pready_o      ( pready_o    ),
        .pslverr_o     ( pslverr_o   ),
        .ctrl_enable_o ( ctrl_enable ),
        .ctrl_signed_o ( ctrl_signed ),
        .ctrl_stereo_o ( ctrl_stereo ),
        .ctrl_mute_o   ( ctrl_mute   ),
        .cen_div_o     ( cen_div     )
    );

    snd_cen_gen u_cen_gen (
        .clk_dac  ( clk_dac     ),
        .rst      ( rst         ),
        .enable_i ( ctrl_enable ),
        .div_i    ( cen_div     ),
        .cen_o    ( cen_dac     )
    );

    snd_pcm_format u_format (
        .clk_dac      ( clk_dac     ),
        .rst          ( rst         ),
        .cen_i        ( cen_dac     ),
        .signed_i     ( ctrl_signed ),
        .stereo_i     ( ctrl_stereo ),
        .mute_i       ( ctrl_mute   ),
        .snd_left_i   ( snd_left_i  ),
        .snd_right_i  ( snd_right_i ),
        .code_left_o  ( code_left   ),
        .code_right_o ( code_right  )
    );

    snd_sd_dac u_dac_left (
        .clk_dac  ( clk_dac        ),
        .rst      ( rst            ),
        .enable_i ( ctrl_enable    ),
        .cen_i    ( cen_dac        ),
        .code_i   ( code_left      ),
        .dac_o    ( snd_pwm_left_o )
    );

    snd_sd_dac u_dac_right (
        .clk_dac  ( clk_dac         ),
        .rst      ( rst             ),
        .enable_i ( ctrl_enable     ),
        .cen_i    ( cen_dac         ),
        .code_i   ( code_right      ),
        .dac_o    ( snd_pwm_right_o )
    );

endmodule

// ==== verification/snd_out_tb.sv ====
module snd_out_tb import snd_pkg::*; ();

    localparam int          WIN_LEN     = 4096;
    localparam int          APB_TIMEOUT = 16;
    localparam logic [15:0] LFSR_SEED   = 16'd43431;

    logic        clk_dac;
    logic        rst;
    logic        psel;
    logic        penable;
    logic        pwrite;
    apb_addr_t   paddr;
    apb_data_t   pwdata;
    apb_data_t   prdata;
    logic        pready;
    logic        pslverr;
    snd_sample_t snd_left;
    snd_sample_t snd_right;
    logic        snd_pwm_left;
    logic        snd_pwm_right;

    logic [15:0] lfsr_state;
    snd_div_t    cur_div;
    int          value_errors;
    int          timeout_errors;

    // handshake between the main flow and the counting process
    logic        win_start;
    logic        win_active;
    logic        win_done;
    int          win_period;
    int          phase;
    int          n_en;
    int          ones_left;
    int          ones_right;
    snd_code_t   exp_left;
    snd_code_t   exp_right;

    snd_out_top UUT (
        .clk_dac         ( clk_dac       ),
        .rst             ( rst           ),
        .psel_i          ( psel          ),
        .penable_i       ( penable       ),
        .pwrite_i        ( pwrite        ),
        .paddr_i         ( paddr         ),
        .pwdata_i        ( pwdata        ),
        .prdata_o        ( prdata        ),
        .pready_o        ( pready        ),
        .pslverr_o       ( pslverr       ),
        .snd_left_i      ( snd_left      ),
        .snd_right_i     ( snd_right     ),
        .snd_pwm_left_o  ( snd_pwm_left  ),
        .snd_pwm_right_o ( snd_pwm_right )
    );

    initial begin
        clk_dac = 1'b0;
        forever #20 clk_dac = ~clk_dac;
    end

    // galois lfsr, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        if (s[0]) begin
            return (s >> 1) ^ 16'hB400;
        end
        return s >> 1;
    endfunction

    // one lfsr step per bit taken
    task automatic rand_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr_state[0]};
            lfsr_state = lfsr_next(lfsr_state);
        end
    endtask

    task automatic rand_sample(output snd_sample_t s);
        logic [31:0] w;
        rand_bits(16, w);
        s = w[15:0];
    endtask

    // expected code: mute picks the midpoint, signed flips the msb, then pad
    function automatic snd_code_t snd_expect_code(input snd_sample_t s, input logic sgn,
                                                  input logic mute);
        snd_sample_t v;
        v = mute ? SND_MUTE_SAMPLE : s;
        if (sgn) begin
            v[15] = ~v[15];
        end
        return {1'b0, v, 3'b000};
    endfunction

    function automatic apb_data_t make_ctrl(input logic en, input logic sgn,
                                            input logic st, input logic mute);
        return {28'd0, mute, st, sgn, en};
    endfunction

    task automatic do_access(input logic wr, input apb_addr_t addr, input apb_data_t wdata,
                             output apb_data_t rdata, output logic err);
        int waited;
        // setup phase
        @(posedge clk_dac);
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        @(posedge clk_dac);
        penable <= 1'b1;
        // setup phase is not an access yet
        expect_value("pready in setup phase", pready, 1'b0);
        expect_value("pslverr in setup phase", pslverr, 1'b0);
        waited = 0;
        do begin
            @(posedge clk_dac);
            waited++;
        end while (!pready && waited < APB_TIMEOUT);
        assert (pready) else begin
            timeout_errors++;
            $display("no pready from the register block within %0d cycles, address 0x%0h",
                     APB_TIMEOUT, addr);
        end
        rdata = prdata;
        err   = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic write_reg(input apb_addr_t addr, input apb_data_t data, output logic err);
        apb_data_t unused;
        do_access(1'b1, addr, data, unused, err);
    endtask

    task automatic read_reg(input apb_addr_t addr, output apb_data_t data, output logic err);
        do_access(1'b0, addr, '0, data, err);
    endtask

    task automatic expect_value(input string what, input logic [31:0] got,
                                input logic [31:0] exp);
        assert (got === exp) else begin
            value_errors++;
            $display("Fail at %0t: %s is 0x%0h, expected 0x%0h", $time, what, got, exp);
        end
    endtask

    task automatic set_div(input snd_div_t d);
        logic err;
        write_reg(SND_DIV_ADDR, {24'd0, d}, err);
        cur_div = d;
    endtask

    task automatic set_samples(input snd_sample_t l, input snd_sample_t r);
        @(posedge clk_dac);
        snd_left  <= l;
        snd_right <= r;
    endtask

    // two lead cycles let a disable reach the dac outputs
    task automatic check_silent(input int n);
        repeat (2) @(posedge clk_dac);
        repeat (n) begin
            @(posedge clk_dac);
            assert (!snd_pwm_left && !snd_pwm_right) else begin
                value_errors++;
                $display("Fail at %0t: pwm output high while disabled", $time);
            end
        end
    endtask

    task automatic check_density(input string side, input int ones, input snd_code_t code);
        longint expect_ones;
        longint diff;
        expect_ones = (longint'(WIN_LEN) * longint'(code)) / 1048576;
        diff = longint'(ones) - expect_ones;
        assert (diff >= -1 && diff <= 1) else begin
            value_errors++;
            $display("Fail at %0t: %s has %0d ones in %0d enables, expected %0d, code 0x%05h",
                     $time, side, ones, WIN_LEN, expect_ones, code);
        end
    endtask

    // one dac value per enable period, counted over WIN_LEN periods
    always @(posedge clk_dac) begin
        if (win_start) begin
            win_active <= 1'b1;
            win_done   <= 1'b0;
            phase      <= 0;
            n_en       <= 0;
            ones_left  <= 0;
            ones_right <= 0;
        end else if (win_active) begin
            if (n_en == WIN_LEN) begin
                check_density("left", ones_left, exp_left);
                check_density("right", ones_right, exp_right);
                win_active <= 1'b0;
                win_done   <= 1'b1;
            end else if (phase == win_period - 1) begin
                phase      <= 0;
                n_en       <= n_en + 1;
                ones_left  <= ones_left + int'(snd_pwm_left);
                ones_right <= ones_right + int'(snd_pwm_right);
            end else begin
                phase <= phase + 1;
            end
        end
    end

    task automatic run_window(input snd_code_t el, input snd_code_t er);
        int waited;
        int period;
        period     = int'(cur_div) + 1;
        exp_left   = el;
        exp_right  = er;
        win_period = period;
        // let a new divider reload and the held codes settle
        repeat (3 * period + 24) @(posedge clk_dac);
        win_start <= 1'b1;
        @(posedge clk_dac);
        win_start <= 1'b0;
        waited = 0;
        do begin
            @(posedge clk_dac);
            waited++;
        end while (!win_done && waited < WIN_LEN * period + 64);
        assert (win_done) else begin
            timeout_errors++;
            $display("density window did not finish within %0d cycles", WIN_LEN * period + 64);
        end
    endtask

    task automatic density_case(input snd_sample_t l, input snd_sample_t r,
                                input logic sgn, input logic st, input logic mute);
        logic err;
        write_reg(SND_CTRL_ADDR, make_ctrl(1'b1, sgn, st, mute), err);
        set_samples(l, r);
        run_window(snd_expect_code(l, sgn, mute), snd_expect_code(st ? r : l, sgn, mute));
    endtask

    initial begin
        apb_data_t   rdata;
        logic        err;
        logic [31:0] rnd;
        snd_sample_t sl;
        snd_sample_t sr;

        psel           = 1'b0;
        penable        = 1'b0;
        pwrite         = 1'b0;
        paddr          = '0;
        pwdata         = '0;
        snd_left       = '0;
        snd_right      = '0;
        rst            = 1'b1;
        lfsr_state     = LFSR_SEED;
        cur_div        = 8'd3;
        value_errors   = 0;
        timeout_errors = 0;
        win_start      = 1'b0;
        win_active     = 1'b0;
        win_done       = 1'b0;
        win_period     = 1;
        repeat (8) @(posedge clk_dac);
        rst <= 1'b0;
        check_silent(64);

        // register map after reset and read back
        read_reg(SND_CTRL_ADDR, rdata, err);
        expect_value("ctrl after reset", rdata, 32'h0);
        expect_value("pslverr on ctrl read", err, 1'b0);
        read_reg(SND_DIV_ADDR, rdata, err);
        expect_value("div after reset", rdata, 32'd3);
        repeat (4) begin
            rand_bits(32, rnd);
            write_reg(SND_CTRL_ADDR, rnd, err);
            read_reg(SND_CTRL_ADDR, rdata, err);
            expect_value("ctrl readback", rdata, rnd & 32'hF);
            rand_bits(32, rnd);
            write_reg(SND_DIV_ADDR, rnd, err);
            read_reg(SND_DIV_ADDR, rdata, err);
            expect_value("div readback", rdata, rnd & 32'hFF);
        end
        write_reg(4'h8, 32'hFFFF_FFFF, err);
        expect_value("pslverr on write to 0x8", err, 1'b1);
        read_reg(SND_DIV_ADDR, rdata, err);
        expect_value("div after bad write", rdata, rnd & 32'hFF);
        read_reg(4'h8, rdata, err);
        expect_value("read of 0x8", rdata, 32'h0);
        expect_value("pslverr on read of 0x8", err, 1'b1);
        set_div(8'd3);
        write_reg(SND_CTRL_ADDR, 32'h0, err);
        check_silent(64);

        // offset binary, stereo
        repeat (2) begin
            rand_sample(sl);
            rand_sample(sr);
            density_case(sl, sr, 1'b0, 1'b1, 1'b0);
        end
        // two's complement, random and extremes
        rand_sample(sl);
        rand_sample(sr);
        density_case(sl, sr, 1'b1, 1'b1, 1'b0);
        density_case(16'h7FFF, 16'h8000, 1'b1, 1'b1, 1'b0);
        density_case(16'h0000, sr, 1'b1, 1'b1, 1'b0);
        // mono, then mute in both formats
        rand_sample(sl);
        rand_sample(sr);
        density_case(sl, sr, 1'b0, 1'b0, 1'b0);
        density_case(sl, sr, 1'b0, 1'b1, 1'b1);
        density_case(sr, sl, 1'b1, 1'b0, 1'b1);
        // other enable rates
        set_div(8'd0);
        rand_sample(sl);
        rand_sample(sr);
        density_case(sl, sr, 1'b0, 1'b1, 1'b0);
        set_div(8'd9);
        density_case(sr, sl, 1'b1, 1'b1, 1'b0);

        // disable while running
        write_reg(SND_CTRL_ADDR, make_ctrl(1'b0, 1'b1, 1'b1, 1'b0), err);
        check_silent(100);

        $display("errors: %0d wrong values, %0d timeouts", value_errors, timeout_errors);
        if (value_errors == 0 && timeout_errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// ==== tb.f ====
logic/snd_pkg.sv
logic/snd_cfg_regs.sv
logic/snd_cen_gen.sv
logic/snd_pcm_format.sv
logic/snd_sd_dac.sv
logic/snd_out_top.sv
verification/snd_out_tb.sv

// ==== Bender.yml ====
package:
  name: snd_out

sources:
  # audio output path
  - files:
      - logic/snd_pkg.sv
      - logic/snd_cfg_regs.sv
      - logic/snd_cen_gen.sv
      - logic/snd_pcm_format.sv
      - logic/snd_sd_dac.sv
      - logic/snd_out_top.sv

  # testbench, top module snd_out_tb
  - target: test
    files:
      - verification/snd_out_tb.sv
